// ==== Makefile ====
# simulator and its options
SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP      = stack_tb
FILELIST = list.f

OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Regression passed

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== list.f ====
+incdir+.
stack_pkg.sv
stack_pointer.sv
stack_ram.sv
stack_control.sv
stack_unit.sv
stack_tb.sv

// ==== stack_control.sv ====
`timescale 1ns/1ps
`include "stack_params.svh"

module stack_control (
	input logic clock,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [9:0] adr,
	input stack_pkg::stack_word_t dat_w,
	output stack_pkg::stack_word_t dat_r,
	output logic ack,
	output stack_pkg::stack_req_t req,
	output logic req_valid,
	input stack_pkg::stack_addr_t esp,
	input stack_pkg::stack_fault_t fault,
	input stack_pkg::stack_word_t rdata
);
	import stack_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_issue,
		st_wait,
		st_ack
	} state_t;

	state_t state;
	logic [1:0] window;
	stack_fault_t sticky;
	// fault of the request in flight
	stack_fault_t last_fault;
	stack_word_t read_data;

	assign window = adr[9:8];

	// window and direction to op
	// master holds these until ack
	always_comb begin
		req.data = dat_w;
		req.disp = adr[7:0];
		req.op = op_none;
		case (window)
			`STACK_WIN_PUSHPOP: req.op = we ? op_push : op_pop;
			`STACK_WIN_ESP: req.op = we ? op_esp_write : op_none;
			`STACK_WIN_FRAME: req.op = we ? op_frame_write : op_frame_read;
			default: req.op = op_none;
		endcase
	end

	// one issue cycle per bus request
	assign req_valid = (state == st_issue);
	assign ack = (state == st_ack);

	// idle, issue, wait, ack
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					// ack is low in idle
					if (cyc && stb) begin
						state <= st_issue;
					end
				end
				st_issue: state <= st_wait;
				st_wait: state <= st_ack;
				default: state <= st_idle;
			endcase
		end
	end

	// read mux gives zero for writes and faulted reads
	always_comb begin
		read_data = '0;
		if (!we && (last_fault == '0)) begin
			case (window)
				`STACK_WIN_PUSHPOP: read_data = rdata;
				`STACK_WIN_ESP: read_data = stack_word_t'(esp);
				`STACK_WIN_FRAME: read_data = rdata;
				default: read_data = stack_word_t'(sticky);
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			dat_r <= '0;
			sticky <= '0;
			last_fault <= '0;
		end else begin
			// pointer answer is valid during issue
			if (state == st_issue) begin
				last_fault <= fault;
				sticky <= stack_fault_t'(sticky | fault);
			end
			// memory data has settled by the end of wait
			if (state == st_wait) begin
				dat_r <= read_data;
				// fault window read clears the flags
				if (!we && (window == `STACK_WIN_FAULT)) begin
					sticky <= '0;
				end
			end
		end
	end

endmodule

// ==== stack_params.svh ====
`ifndef STACK_PARAMS_SVH
`define STACK_PARAMS_SVH

// memory size in bytes
`define STACK_BYTES 256

// bytes moved by one access
`define STACK_WORD_BYTES 4

// esp out of reset points one past the top, stack empty
`define STACK_ESP_RESET 256

// window codes on adr[9:8]
`define STACK_WIN_PUSHPOP 2'd0
`define STACK_WIN_ESP 2'd1
`define STACK_WIN_FRAME 2'd2
`define STACK_WIN_FAULT 2'd3

`endif

// ==== stack_pkg.sv ====
`include "stack_params.svh"

package stack_pkg;

	// one bus word
	typedef logic [8*`STACK_WORD_BYTES-1:0] stack_word_t;

	// byte address or esp, one bit wider than memory so the top can be held
	typedef logic [$clog2(`STACK_BYTES):0] stack_addr_t;

	// what the control block asks the pointer to do
	typedef enum logic [2:0] {
		op_none,
		op_push,
		op_pop,
		op_esp_write,
		op_frame_read,
		op_frame_write
	} stack_op_t;

	// control to pointer
	typedef struct packed {
		stack_op_t op;
		stack_word_t data;
		// frame displacement from adr[7:0]
		logic [7:0] disp;
	} stack_req_t;

	// pointer to memory
	typedef struct packed {
		logic we;
		// byte index into memory
		logic [$clog2(`STACK_BYTES)-1:0] addr;
		stack_word_t wdata;
	} stack_mem_t;

	// fault report, also the sticky register layout (bits 2 to 0)
	typedef struct packed {
		logic overflow;
		logic underflow;
		logic frame_range;
	} stack_fault_t;

endpackage

// ==== stack_pointer.sv ====
`timescale 1ns/1ps
`include "stack_params.svh"

module stack_pointer (
	input logic clock,
	input logic reset,
	input stack_pkg::stack_req_t req,
	input logic req_valid,
	output stack_pkg::stack_addr_t esp,
	output stack_pkg::stack_fault_t fault,
	output stack_pkg::stack_mem_t mem
);
	import stack_pkg::*;

	stack_addr_t esp_next;
	stack_addr_t eff_addr;
	stack_addr_t esp_wr;
	// one extra bit so esp plus disp never wraps
	logic [$bits(stack_addr_t):0] frame_sum;
	logic [$bits(stack_addr_t):0] frame_end;
	logic write_op;
	logic commit;

	// frame address and its last byte
	assign frame_sum = {1'b0, esp} + ($bits(stack_addr_t) + 1)'(req.disp);
	assign frame_end = frame_sum + ($bits(stack_addr_t) + 1)'(`STACK_WORD_BYTES - 1);
	// new esp value from the write data, low bits only
	assign esp_wr = req.data[$bits(stack_addr_t)-1:0];

	// effective address, next esp and range check per op
	always_comb begin
		fault = '0;
		esp_next = esp;
		eff_addr = esp;
		write_op = 1'b0;
		case (req.op)
			op_push: begin
				// pre-decrement then store at the new top
				esp_next = esp - stack_addr_t'(`STACK_WORD_BYTES);
				eff_addr = esp_next;
				write_op = 1'b1;
				fault.overflow = (esp < stack_addr_t'(`STACK_WORD_BYTES));
			end
			op_pop: begin
				// read at esp, post-increment
				esp_next = esp + stack_addr_t'(`STACK_WORD_BYTES);
				fault.underflow = (esp > stack_addr_t'(`STACK_BYTES - `STACK_WORD_BYTES));
			end
			op_esp_write: begin
				esp_next = esp_wr;
				fault.frame_range = (esp_wr > stack_addr_t'(`STACK_BYTES));
			end
			op_frame_read: begin
				eff_addr = frame_sum[$bits(stack_addr_t)-1:0];
				fault.frame_range = (frame_end > ($bits(frame_end))'(`STACK_BYTES - 1));
			end
			op_frame_write: begin
				eff_addr = frame_sum[$bits(stack_addr_t)-1:0];
				write_op = 1'b1;
				fault.frame_range = (frame_end > ($bits(frame_end))'(`STACK_BYTES - 1));
			end
			default: begin
				// no op leaves everything as is
			end
		endcase
	end

	// only a clean request touches memory or esp
	assign commit = req_valid && (fault == '0);

	assign mem.we = commit && write_op;
	assign mem.addr = eff_addr[$clog2(`STACK_BYTES)-1:0];
	assign mem.wdata = req.data;

	always_ff @(posedge clock) begin
		if (reset) begin
			esp <= stack_addr_t'(`STACK_ESP_RESET);
		end else if (commit) begin
			esp <= esp_next;
		end
	end

endmodule

// ==== stack_ram.sv ====
`timescale 1ns/1ps
`include "stack_params.svh"

module stack_ram (
	input logic clock,
	input stack_pkg::stack_mem_t mem,
	output stack_pkg::stack_word_t rdata
);

	// byte wide storage, no reset
	logic [7:0] bytes [`STACK_BYTES];

	// byte index of each lane, wraps at the memory size
	logic [$clog2(`STACK_BYTES)-1:0] lane_addr [`STACK_WORD_BYTES];

	always_comb begin
		for (int i = 0; i < `STACK_WORD_BYTES; i++) begin
			lane_addr[i] = mem.addr + ($clog2(`STACK_BYTES))'(i);
		end
	end

	// little-endian write, lane 0 at the lowest address
	always_ff @(posedge clock) begin
		if (mem.we) begin
			for (int i = 0; i < `STACK_WORD_BYTES; i++) begin
				bytes[lane_addr[i]] <= mem.wdata[8*i +: 8];
			end
		end
	end

	// registered read every cycle
	// old data on a same-edge write, which no caller reads
	always_ff @(posedge clock) begin
		for (int i = 0; i < `STACK_WORD_BYTES; i++) begin
			rdata[8*i +: 8] <= bytes[lane_addr[i]];
		end
	end

endmodule

// ==== stack_tb.sv ====
`timescale 1ns/1ps
`include "stack_params.svh"

module stack_tb;
	import stack_pkg::*;

	// clock period in ns
	localparam int PERIOD = 100;
	// falling edges from driving a request to seeing ack
	// request edge plus two more rising edges
	localparam int ACK_EDGES = 3;
	// stop waiting for ack after this many cycles
	localparam int ACK_LIMIT = 10;
	// reset length in cycles
	localparam int RESET_CYCLES = 10;

	logic clock;
	logic reset;
	logic cyc;
	logic stb;
	logic we;
	logic [9:0] adr;
	stack_word_t dat_w;
	stack_word_t dat_r;
	logic ack;

	// trace contents, one entry per bus transaction
	logic [7:0] kind_q [$];
	logic [9:0] adr_q [$];
	stack_word_t wdata_q [$];
	stack_word_t expect_q [$];

	// error counters
	int mismatches;
	int ack_errors;
	int trace_errors;
	// set once the trace is in memory, starts the watchdog
	logic trace_loaded;
	// xorshift state for idle gaps
	logic [31:0] rng_state;

	stack_unit DUT (
		.clock(clock),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.dat_r(dat_r),
		.ack(ack)
	);

	initial clock = 1'b0;
	always #(PERIOD / 2) clock = ~clock;

	// 32-bit xorshift step
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// label for error lines
	function automatic string window_name(input logic [1:0] window);
		case (window)
			`STACK_WIN_PUSHPOP: return "pop";
			`STACK_WIN_ESP: return "esp";
			`STACK_WIN_FRAME: return "frame";
			default: return "fault";
		endcase
	endfunction

	task automatic check_word(input string name, input stack_word_t got,
		input stack_word_t expected);
		if (got !== expected) begin
			mismatches++;
			$display("Mismatch at %0d ns: %s got %h expected %h",
				$time, name, got, expected);
		end
	endtask

	// flag order is overflow, underflow, frame_range
	task automatic check_fault(input string name, input stack_fault_t got,
		input stack_fault_t expected);
		if (got !== expected) begin
			mismatches++;
			$display("Mismatch at %0d ns: %s flags got %b expected %b",
				$time, name, got, expected);
		end
	endtask

	// read the whole trace into the queues
	task automatic load_trace();
		int fd;
		int code;
		int c;
		logic done;
		logic [7:0] kind;
		logic [9:0] a;
		stack_word_t d;
		stack_word_t e;
		done = 1'b0;
		fd = $fopen("stack_trace.txt", "r");
		if (fd == 0) begin
			trace_errors++;
			$display("Could not open stack_trace.txt for reading");
			return;
		end
		while (!done) begin
			// first non-blank character of a line
			code = $fscanf(fd, " %c", kind);
			if (code != 1) begin
				done = 1'b1;
			end else if (kind == "#") begin
				// comment, skip to end of line
				c = $fgetc(fd);
				while (c != 10 && c != -1) begin
					c = $fgetc(fd);
				end
			end else if (kind == "W" || kind == "R") begin
				code = $fscanf(fd, "%h %h %h", a, d, e);
				if (code != 3) begin
					trace_errors++;
					$display("Trace entry %0d in stack_trace.txt is malformed",
						kind_q.size() + 1);
					done = 1'b1;
				end else begin
					kind_q.push_back(kind);
					adr_q.push_back(a);
					wdata_q.push_back(d);
					expect_q.push_back(e);
				end
			end else begin
				trace_errors++;
				$display("Unknown transaction kind %c in stack_trace.txt", kind);
				done = 1'b1;
			end
		end
		$fclose(fd);
	endtask

	// one Wishbone classic cycle, called on a falling edge
	task automatic bus_cycle(input logic write, input logic [9:0] addr,
		input stack_word_t wdata, output stack_word_t rdata);
		int edges;
		edges = 0;
		rdata = '0;
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = addr;
		dat_w = wdata;
		// sample ack on falling edges only
		while (!ack && edges < ACK_LIMIT) begin
			@(negedge clock);
			edges++;
		end
		if (!ack) begin
			ack_errors++;
			$display("No ack for adr %h within %0d cycles, at %0d ns",
				addr, ACK_LIMIT, $time);
		end else begin
			rdata = dat_r;
			if (edges != ACK_EDGES) begin
				ack_errors++;
				$display("Ack for adr %h came %0d cycles after the request instead of %0d",
					addr, edges - 1, ACK_EDGES - 1);
			end
		end
		// release on the falling edge after ack rose
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic check_read(input int index, input stack_word_t got);
		string name;
		logic [1:0] window;
		window = adr_q[index][9:8];
		name = $sformatf("dat_r (%s window, trace entry %0d)",
			window_name(window), index + 1);
		if (window == `STACK_WIN_FAULT) begin
			// flags in bits 2 to 0, the rest must read zero
			check_fault(name, stack_fault_t'(got[2:0]),
				stack_fault_t'(expect_q[index][2:0]));
			check_word(name, got & ~32'h7, expect_q[index] & ~32'h7);
		end else begin
			check_word(name, got, expect_q[index]);
		end
	endtask

	initial begin
		stack_word_t got;
		int gap;
		int total;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		reset = 1'b1;
		mismatches = 0;
		ack_errors = 0;
		trace_errors = 0;
		rng_state = 32'ha265c4c2;
		trace_loaded = 1'b0;
		load_trace();
		trace_loaded = 1'b1;
		repeat (RESET_CYCLES) @(negedge clock);
		reset = 1'b0;
		// bus outputs quiet out of reset
		if (ack !== 1'b0) begin
			ack_errors++;
			$display("Ack is high right after reset, at %0d ns", $time);
		end
		check_word("dat_r after reset", dat_r, '0);
		for (int i = 0; i < kind_q.size(); i++) begin
			// one or two idle cycles between requests
			rng_state = xorshift32(rng_state);
			gap = rng_state[0] ? 1 : 0;
			repeat (1 + gap) @(negedge clock);
			bus_cycle(kind_q[i] == "W", adr_q[i], wdata_q[i], got);
			if (kind_q[i] == "R") begin
				check_read(i, got);
			end
		end
		repeat (2) @(negedge clock);
		total = mismatches + ack_errors + trace_errors;
		$display("%0d errors: %0d mismatches, %0d ack timing, %0d trace, %0d transactions",
			total, mismatches, ack_errors, trace_errors, kind_q.size());
		if (total == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// watchdog, five cycles per transaction plus reset margin
	initial begin
		int limit_cycles;
		wait (trace_loaded === 1'b1);
		limit_cycles = kind_q.size() * 5 + 20;
		repeat (limit_cycles) @(posedge clock);
		$display("Timeout: the trace did not finish within %0d clock cycles", limit_cycles);
		$display("Regression failed");
		$finish;
	end

endmodule

// ==== stack_trace.txt ====
# columns: kind adr dat_w expected_dat_r, all hex; W writes, R reads and checks dat_r
# adr[9:8] window: 0 push/pop, 1 esp, 2 frame (adr[7:0] is disp), 3 fault flags
# state after reset
R 100 00000000 00000100
R 300 00000000 00000000
# five pushes, five pops in reverse
W 000 11111111 00000000
W 000 22222222 00000000
W 000 33333333 00000000
W 000 44444444 00000000
W 000 55555555 00000000
R 100 00000000 000000ec
R 000 00000000 55555555
R 000 00000000 44444444
R 000 00000000 33333333
R 000 00000000 22222222
R 000 00000000 11111111
R 100 00000000 00000100
# frame reads at esp 244, aligned and byte misaligned
W 000 a1a2a3a4 00000000
W 000 b1b2b3b4 00000000
W 000 c1c2c3c4 00000000
R 200 00000000 c1c2c3c4
R 204 00000000 b1b2b3b4
R 201 00000000 b4c1c2c3
R 208 00000000 a1a2a3a4
R 206 00000000 a3a4b1b2
# frame writes then pops
W 200 deadbeef 00000000
R 000 00000000 deadbeef
W 202 12345678 00000000
R 200 00000000 5678b3b4
R 000 00000000 5678b3b4
R 000 00000000 a1a21234
R 100 00000000 00000100
# pop on empty stack, underflow
R 000 00000000 00000000
R 100 00000000 00000100
R 300 00000000 00000002
R 300 00000000 00000000
# push at esp 0, overflow
W 100 00000000 00000000
R 100 00000000 00000000
W 000 cafef00d 00000000
R 100 00000000 00000000
R 300 00000000 00000004
R 300 00000000 00000000
# frame range at esp 252
W 100 000000fc 00000000
R 200 00000000 a1a21234
R 208 00000000 00000000
R 100 00000000 000000fc
R 300 00000000 00000001
R 300 00000000 00000000
R 203 00000000 00000000
W 100 00000104 00000000
R 100 00000000 000000fc
R 300 00000000 00000001
R 300 00000000 00000000
W 20c 77777777 00000000
R 200 00000000 a1a21234
R 300 00000000 00000001
# esp takes the low 9 bits only
W 100 ffffff00 00000000
R 100 00000000 00000100
# two flags pile up in the sticky register
R 000 00000000 00000000
W 100 00000003 00000000
W 000 0badf00d 00000000
R 100 00000000 00000003
R 300 00000000 00000006
R 300 00000000 00000000
# fault window write is ignored
W 300 00000007 00000000
R 300 00000000 00000000
W 100 00000100 00000000
R 100 00000000 00000100

// ==== stack_unit.sv ====
`timescale 1ns/1ps

module stack_unit (
	input logic clock,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [9:0] adr,
	input stack_pkg::stack_word_t dat_w,
	output stack_pkg::stack_word_t dat_r,
	output logic ack
);
	import stack_pkg::*;

	stack_req_t req;
	logic req_valid;
	stack_addr_t esp;
	stack_fault_t fault;
	stack_mem_t mem;
	stack_word_t rdata;

	// bus slave and fault register
	stack_control u_control (
		.clock(clock),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.dat_r(dat_r),
		.ack(ack),
		.req(req),
		.req_valid(req_valid),
		.esp(esp),
		.fault(fault),
		.rdata(rdata)
	);

	// esp and range checks
	stack_pointer u_pointer (
		.clock(clock),
		.reset(reset),
		.req(req),
		.req_valid(req_valid),
		.esp(esp),
		.fault(fault),
		.mem(mem)
	);

	stack_ram u_ram (
		.clock(clock),
		.mem(mem),
		.rdata(rdata)
	);

endmodule
